//--- iob_cache_pkg.sv
`default_nettype none

package iob_cache_pkg;

   // Host data path
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // Direct-mapped geometry, one word per line
   localparam int LINE_NUM = 16;
   localparam int INDEX_W  = 4;
   localparam int TAG_W    = ADDR_W - INDEX_W - 2;

   // Control block register map
   localparam int CTRL_ADDR_W = 2;

   typedef enum logic [CTRL_ADDR_W-1:0] {
      CTRL_HIT_CNT    = 0,
      CTRL_MISS_CNT   = 1,
      CTRL_RST_CNT    = 2,
      CTRL_INVALIDATE = 3
   } ctrl_reg_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_MISS_READ,
      ST_WRITE_THROUGH
   } mem_state_t;

endpackage

`default_nettype wire

//--- iob_cache_if.sv
`default_nettype none

// Front end to cache memory
interface iob_cache_req_if;
   logic                                req;
   logic [iob_cache_pkg::ADDR_W-1:0]    addr;
   logic [iob_cache_pkg::DATA_W-1:0]    wdata;
   logic [iob_cache_pkg::STRB_W-1:0]    wstrb;
   logic                                we;
   logic [iob_cache_pkg::DATA_W-1:0]    rdata;
   logic                                ack;

   modport front (output req, addr, wdata, wstrb, we, input rdata, ack);
   modport cache (input req, addr, wdata, wstrb, we, output rdata, ack);
endinterface

// Cache memory to back end
interface iob_cache_mem_if;
   logic                                req;
   logic                                we;
   logic [iob_cache_pkg::ADDR_W-1:0]    addr;
   logic [iob_cache_pkg::DATA_W-1:0]    wdata;
   logic [iob_cache_pkg::STRB_W-1:0]    wstrb;
   logic [iob_cache_pkg::DATA_W-1:0]    rdata;
   logic                                ack;

   modport client (output req, we, addr, wdata, wstrb, input rdata, ack);
   modport port (input req, we, addr, wdata, wstrb, output rdata, ack);
endinterface

// Front end to control registers
interface iob_cache_ctrl_if;
   logic                                  req;
   logic                                  we;
   logic [iob_cache_pkg::CTRL_ADDR_W-1:0] addr;
   logic [iob_cache_pkg::DATA_W-1:0]      wdata;
   logic [iob_cache_pkg::DATA_W-1:0]      rdata;
   logic                                  ack;

   modport front (output req, we, addr, wdata, input rdata, ack);
   modport ctrl (input req, we, addr, wdata, output rdata, ack);
endinterface

`default_nettype wire

//--- iob_cache_front_end.sv
`default_nettype none

module iob_cache_front_end (
   input  wire logic                             clk_i,
   input  wire logic                             rst_n_i,
   input  wire logic                             avalid_i,
   input  wire logic [iob_cache_pkg::ADDR_W:0]   addr_i,
   input  wire logic [iob_cache_pkg::DATA_W-1:0] wdata_i,
   input  wire logic [iob_cache_pkg::STRB_W-1:0] wstrb_i,
   output logic      [iob_cache_pkg::DATA_W-1:0] rdata_o,
   output logic                                  rvalid_o,
   output logic                                  ready_o,
   iob_cache_req_if.front                        cache_if,
   iob_cache_ctrl_if.front                       ctrl_if
);

   logic                               req_r;
   logic                               sel_ctrl_r;
   logic                               we_r;
   logic [iob_cache_pkg::ADDR_W-1:0]   addr_r;
   logic [iob_cache_pkg::DATA_W-1:0]   wdata_r;
   logic [iob_cache_pkg::STRB_W-1:0]   wstrb_r;
   logic                               accept;
   logic                               ack;

   assign ack     = cache_if.ack | ctrl_if.ack;
   assign ready_o = ~req_r | ack;
   assign accept  = avalid_i & ready_o;

   // Reads complete with rvalid, writes complete silently
   assign rvalid_o = ack & ~we_r;
   assign rdata_o  = ctrl_if.ack ? ctrl_if.rdata : cache_if.rdata;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         req_r      <= 1'b0;
         sel_ctrl_r <= 1'b0;
         we_r       <= 1'b0;
      end else if (accept) begin
         req_r      <= 1'b1;
         sel_ctrl_r <= addr_i[iob_cache_pkg::ADDR_W];
         we_r       <= |wstrb_i;
      end else if (ack) begin
         req_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_r  <= addr_i[iob_cache_pkg::ADDR_W-1:0];
         wdata_r <= wdata_i;
         wstrb_r <= wstrb_i;
      end
   end

   // Top address bit picks the control block
   assign cache_if.req   = req_r & ~sel_ctrl_r;
   assign cache_if.addr  = addr_r;
   assign cache_if.wdata = wdata_r;
   assign cache_if.wstrb = wstrb_r;
   assign cache_if.we    = we_r;

   assign ctrl_if.req   = req_r & sel_ctrl_r;
   assign ctrl_if.we    = we_r;
   assign ctrl_if.addr  = addr_r[iob_cache_pkg::CTRL_ADDR_W-1:0];
   assign ctrl_if.wdata = wdata_r;

endmodule

`default_nettype wire

//--- iob_cache_memory.sv
`default_nettype none

module iob_cache_memory (
   input  wire logic         clk_i,
   input  wire logic         rst_n_i,
   iob_cache_req_if.cache    req_if,
   iob_cache_mem_if.client   mem_if,
   input  wire logic         invalidate_i,
   output logic              hit_o,
   output logic              miss_o
);

   logic [iob_cache_pkg::TAG_W-1:0]    tag_mem  [iob_cache_pkg::LINE_NUM];
   logic [iob_cache_pkg::DATA_W-1:0]   data_mem [iob_cache_pkg::LINE_NUM];
   logic [iob_cache_pkg::LINE_NUM-1:0] valid_r;

   iob_cache_pkg::mem_state_t          state_r;
   iob_cache_pkg::mem_state_t          state_nxt;

   logic [iob_cache_pkg::INDEX_W-1:0]  idx;
   logic [iob_cache_pkg::TAG_W-1:0]    tag;
   logic                               hit;
   logic                               lookup;
   logic                               fill_en;
   logic                               wr_hit;

   // Word address split into tag and line index
   assign idx = req_if.addr[iob_cache_pkg::INDEX_W+1:2];
   assign tag = req_if.addr[iob_cache_pkg::ADDR_W-1:iob_cache_pkg::INDEX_W+2];

   assign hit    = valid_r[idx] && (tag_mem[idx] == tag);
   assign lookup = (state_r == iob_cache_pkg::ST_LOOKUP);

   // One pulse per data access, writes included
   assign hit_o  = lookup & hit;
   assign miss_o = lookup & ~hit;

   assign fill_en = (state_r == iob_cache_pkg::ST_MISS_READ) & mem_if.ack;
   assign wr_hit  = lookup & req_if.we & hit;

   always_comb begin
      state_nxt  = state_r;
      req_if.ack = 1'b0;
      case (state_r)
         iob_cache_pkg::ST_IDLE: begin
            if (req_if.req) begin
               state_nxt = iob_cache_pkg::ST_LOOKUP;
            end
         end
         iob_cache_pkg::ST_LOOKUP: begin
            if (req_if.we) begin
               state_nxt = iob_cache_pkg::ST_WRITE_THROUGH;
            end else if (hit) begin
               req_if.ack = 1'b1;
               state_nxt  = iob_cache_pkg::ST_IDLE;
            end else begin
               state_nxt = iob_cache_pkg::ST_MISS_READ;
            end
         end
         default: begin
            // Miss fill or write-through finishes with the memory ack
            if (mem_if.ack) begin
               req_if.ack = 1'b1;
               state_nxt  = iob_cache_pkg::ST_IDLE;
            end
         end
      endcase
   end

   assign req_if.rdata = (state_r == iob_cache_pkg::ST_MISS_READ) ? mem_if.rdata : data_mem[idx];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r <= iob_cache_pkg::ST_IDLE;
         valid_r <= '0;
      end else begin
         state_r <= state_nxt;
         if (state_r == iob_cache_pkg::ST_IDLE && invalidate_i) begin
            valid_r <= '0;
         end else if (fill_en) begin
            valid_r[idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_en) begin
         data_mem[idx] <= mem_if.rdata;
         tag_mem[idx]  <= tag;
      end else if (wr_hit) begin
         for (int b = 0; b < iob_cache_pkg::STRB_W; b++) begin
            if (req_if.wstrb[b]) begin
               data_mem[idx][8*b +: 8] <= req_if.wdata[8*b +: 8];
            end
         end
      end
   end

   // Front end holds the request stable, so it is forwarded as is
   assign mem_if.req   = (state_r == iob_cache_pkg::ST_MISS_READ) ||
                         (state_r == iob_cache_pkg::ST_WRITE_THROUGH);
   assign mem_if.we    = req_if.we;
   assign mem_if.addr  = req_if.addr;
   assign mem_if.wdata = req_if.wdata;
   assign mem_if.wstrb = req_if.wstrb;

endmodule

`default_nettype wire

//--- iob_cache_back_end.sv
`default_nettype none

module iob_cache_back_end (
   input  wire logic                             clk_i,
   input  wire logic                             rst_n_i,
   iob_cache_mem_if.port                         cache_if,
   output logic                                  mem_req_o,
   output logic                                  mem_we_o,
   output logic      [iob_cache_pkg::ADDR_W-1:0] mem_addr_o,
   output logic      [iob_cache_pkg::DATA_W-1:0] mem_wdata_o,
   output logic      [iob_cache_pkg::STRB_W-1:0] mem_wstrb_o,
   input  wire logic [iob_cache_pkg::DATA_W-1:0] mem_rdata_i,
   input  wire logic                             mem_ack_i
);

   logic mem_req_r;
   logic capture;

   // Take a new access only while the port is free
   assign capture = cache_if.req & ~mem_req_r;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mem_req_r <= 1'b0;
      end else if (mem_req_r) begin
         if (mem_ack_i) begin
            mem_req_r <= 1'b0;
         end
      end else if (cache_if.req) begin
         mem_req_r <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (capture) begin
         mem_we_o    <= cache_if.we;
         mem_addr_o  <= cache_if.addr;
         mem_wdata_o <= cache_if.wdata;
         mem_wstrb_o <= cache_if.wstrb;
      end
   end

   assign mem_req_o = mem_req_r;

   assign cache_if.ack   = mem_req_r & mem_ack_i;
   assign cache_if.rdata = mem_rdata_i;

endmodule

`default_nettype wire

//--- iob_cache_control.sv
`default_nettype none

module iob_cache_control (
   input  wire logic     clk_i,
   input  wire logic     rst_n_i,
   iob_cache_ctrl_if.ctrl ctrl_if,
   input  wire logic     hit_i,
   input  wire logic     miss_i,
   output logic          invalidate_o
);

   logic [iob_cache_pkg::DATA_W-1:0] hit_cnt;
   logic [iob_cache_pkg::DATA_W-1:0] miss_cnt;
   logic                             ack_r;
   logic                             wr_cmd;
   iob_cache_pkg::ctrl_reg_t         reg_sel;

   assign reg_sel = iob_cache_pkg::ctrl_reg_t'(ctrl_if.addr);

   // Fixed one cycle latency
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_r <= 1'b0;
      end else begin
         ack_r <= ctrl_if.req & ~ack_r;
      end
   end

   assign ctrl_if.ack = ack_r;
   assign wr_cmd      = ack_r & ctrl_if.we;

   assign invalidate_o = wr_cmd && (reg_sel == iob_cache_pkg::CTRL_INVALIDATE);

   // Writes to a counter preset it, counting saturates
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hit_cnt  <= '0;
         miss_cnt <= '0;
      end else if (wr_cmd && reg_sel == iob_cache_pkg::CTRL_RST_CNT) begin
         hit_cnt  <= '0;
         miss_cnt <= '0;
      end else begin
         if (wr_cmd && reg_sel == iob_cache_pkg::CTRL_HIT_CNT) begin
            hit_cnt <= ctrl_if.wdata;
         end else if (hit_i && ~&hit_cnt) begin
            hit_cnt <= hit_cnt + 1'b1;
         end
         if (wr_cmd && reg_sel == iob_cache_pkg::CTRL_MISS_CNT) begin
            miss_cnt <= ctrl_if.wdata;
         end else if (miss_i && ~&miss_cnt) begin
            miss_cnt <= miss_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      case (reg_sel)
         iob_cache_pkg::CTRL_HIT_CNT:  ctrl_if.rdata = hit_cnt;
         iob_cache_pkg::CTRL_MISS_CNT: ctrl_if.rdata = miss_cnt;
         default:                      ctrl_if.rdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- iob_cache.sv
`default_nettype none

module iob_cache (
   input  wire logic                             clk_i,
   input  wire logic                             rst_n_i,
   // Host port
   input  wire logic                             avalid_i,
   input  wire logic [iob_cache_pkg::ADDR_W:0]   addr_i,
   input  wire logic [iob_cache_pkg::DATA_W-1:0] wdata_i,
   input  wire logic [iob_cache_pkg::STRB_W-1:0] wstrb_i,
   output logic      [iob_cache_pkg::DATA_W-1:0] rdata_o,
   output logic                                  rvalid_o,
   output logic                                  ready_o,
   // External memory port
   output logic                                  mem_req_o,
   output logic                                  mem_we_o,
   output logic      [iob_cache_pkg::ADDR_W-1:0] mem_addr_o,
   output logic      [iob_cache_pkg::DATA_W-1:0] mem_wdata_o,
   output logic      [iob_cache_pkg::STRB_W-1:0] mem_wstrb_o,
   input  wire logic [iob_cache_pkg::DATA_W-1:0] mem_rdata_i,
   input  wire logic                             mem_ack_i
);

   logic hit;
   logic miss;
   logic invalidate;

   iob_cache_req_if  req_if ();
   iob_cache_mem_if  mem_if ();
   iob_cache_ctrl_if ctrl_if ();

   iob_cache_front_end front_end0 (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .avalid_i (avalid_i),
      .addr_i   (addr_i),
      .wdata_i  (wdata_i),
      .wstrb_i  (wstrb_i),
      .rdata_o  (rdata_o),
      .rvalid_o (rvalid_o),
      .ready_o  (ready_o),
      .cache_if (req_if.front),
      .ctrl_if  (ctrl_if.front)
   );

   iob_cache_memory memory0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_if       (req_if.cache),
      .mem_if       (mem_if.client),
      .invalidate_i (invalidate),
      .hit_o        (hit),
      .miss_o       (miss)
   );

   iob_cache_back_end back_end0 (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cache_if    (mem_if.port),
      .mem_req_o   (mem_req_o),
      .mem_we_o    (mem_we_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o),
      .mem_wstrb_o (mem_wstrb_o),
      .mem_rdata_i (mem_rdata_i),
      .mem_ack_i   (mem_ack_i)
   );

   iob_cache_control control0 (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .ctrl_if      (ctrl_if.ctrl),
      .hit_i        (hit),
      .miss_i       (miss),
      .invalidate_o (invalidate)
   );

endmodule

`default_nettype wire

//--- iob_cache_clk_gen.sv
`default_nettype none

module iob_cache_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   // Low over the first two rising edges
   initial begin
      rst_n_o = 1'b0;
      #200 rst_n_o = 1'b1;
   end
endmodule

`default_nettype wire

//--- iob_cache_props.sv
`default_nettype none

module iob_cache_props (
   input wire logic                             clk_i,
   input wire logic                             rst_n_i,
   input wire logic                             avalid_i,
   input wire logic [iob_cache_pkg::STRB_W-1:0] wstrb_i,
   input wire logic                             ready_o,
   input wire logic                             rvalid_o,
   input wire logic                             mem_req_o,
   input wire logic                             mem_we_o,
   input wire logic [iob_cache_pkg::ADDR_W-1:0] mem_addr_o,
   input wire logic [iob_cache_pkg::DATA_W-1:0] mem_wdata_o,
   input wire logic [iob_cache_pkg::STRB_W-1:0] mem_wstrb_o,
   input wire logic                             mem_ack_i
);
   timeunit 1ns;
   timeprecision 1ps;

   logic wr_in_flight;
   int   fail_count = 0;

   // Latest accepted host request is a write
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_in_flight <= 1'b0;
      end else if (avalid_i && ready_o) begin
         wr_in_flight <= |wstrb_i;
      end
   end

   mem_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o) && $stable(mem_we_o)
         && $stable(mem_wdata_o) && $stable(mem_wstrb_o))
      else begin
         $error("memory request dropped or changed before its acknowledge");
         fail_count++;
      end

   no_rvalid_on_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wr_in_flight |-> !rvalid_o)
      else begin
         $error("rvalid raised for a write");
         fail_count++;
      end

   reset_state: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> ready_o && !mem_req_o && !rvalid_o)
      else begin
         $error("wrong port state right after reset");
         fail_count++;
      end
endmodule

bind iob_cache iob_cache_props props0 (
   .clk_i       (clk_i),
   .rst_n_i     (rst_n_i),
   .avalid_i    (avalid_i),
   .wstrb_i     (wstrb_i),
   .ready_o     (ready_o),
   .rvalid_o    (rvalid_o),
   .mem_req_o   (mem_req_o),
   .mem_we_o    (mem_we_o),
   .mem_addr_o  (mem_addr_o),
   .mem_wdata_o (mem_wdata_o),
   .mem_wstrb_o (mem_wstrb_o),
   .mem_ack_i   (mem_ack_i)
);

`default_nettype wire

//--- iob_cache_tb.sv
`default_nettype none

module iob_cache_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT = 200;
   localparam int WORDS   = 64;

   logic        clk;
   logic        rst_n;
   logic        avalid_i;
   logic [32:0] addr_i;
   logic [31:0] wdata_i;
   logic [3:0]  wstrb_i;
   logic [31:0] rdata_o;
   logic        rvalid_o;
   logic        ready_o;
   logic        mem_req_o;
   logic        mem_we_o;
   logic [31:0] mem_addr_o;
   logic [31:0] mem_wdata_o;
   logic [3:0]  mem_wstrb_o;
   logic [31:0] mem_rdata_i;
   logic        mem_ack_i;

   logic [31:0] ext_mem [WORDS];
   logic [31:0] ref_mem [WORDS];
   logic [25:0] ref_tag [16];
   logic [15:0] ref_valid;
   logic [31:0] exp_q [$];
   logic [32:0] exp_addr_q [$];
   logic [31:0] wr_addr_q [$];
   logic [31:0] wr_data_q [$];
   logic [3:0]  wr_strb_q [$];
   logic [31:0] wr_mask;
   logic        mem_busy = 1'b0;
   int          mem_wait;
   int          max_delay;
   int          ref_hits;
   int          ref_misses;
   int          exp_mem_reads;
   int          exp_mem_writes;
   int          mem_reads;
   int          mem_writes;
   int          error_count;
   int          test_errors;
   int          test_count;
   int          failed_tests;
   int          reads_before;

   iob_cache_clk_gen clk_gen0 (.clk_o(clk), .rst_n_o(rst_n));

   iob_cache dut0 (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .avalid_i    (avalid_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .wstrb_i     (wstrb_i),
      .rdata_o     (rdata_o),
      .rvalid_o    (rvalid_o),
      .ready_o     (ready_o),
      .mem_req_o   (mem_req_o),
      .mem_we_o    (mem_we_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o),
      .mem_wstrb_o (mem_wstrb_o),
      .mem_rdata_i (mem_rdata_i),
      .mem_ack_i   (mem_ack_i)
   );

   function automatic logic [31:0] fill_word(input int w);
      return 32'hC0DE0000 ^ (w * 32'h01F30047);
   endfunction

   function automatic logic [31:0] strobe_mask(input logic [3:0] s);
      return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
         error_count++;
      end
   endtask

   task automatic abort_run(input string why);
      $display("ERROR at %0t ns: %s", $time, why);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   // Reference cache, updated in request order at acceptance
   task automatic model_access(input logic [32:0] a, input logic [31:0] d, input logic [3:0] s);
      logic [3:0] idx;
      logic       hit;
      idx = a[5:2];
      if (a[32]) begin
         if (s == 4'h0) begin
            exp_q.push_back((a[1:0] == iob_cache_pkg::CTRL_HIT_CNT) ? ref_hits : ref_misses);
            exp_addr_q.push_back(a);
         end else if (a[1:0] == iob_cache_pkg::CTRL_RST_CNT) begin
            ref_hits   = 0;
            ref_misses = 0;
         end else if (a[1:0] == iob_cache_pkg::CTRL_INVALIDATE) begin
            ref_valid = '0;
         end
      end else begin
         hit = ref_valid[idx] && (ref_tag[idx] == a[31:6]);
         if (hit) begin
            ref_hits++;
         end else begin
            ref_misses++;
         end
         if (s == 4'h0) begin
            if (!hit) begin
               exp_mem_reads++;
               ref_valid[idx] = 1'b1;
               ref_tag[idx]   = a[31:6];
            end
            exp_q.push_back(ref_mem[a[7:2]]);
            exp_addr_q.push_back(a);
         end else begin
            // Write-through without allocation on a miss
            ref_mem[a[7:2]] = (ref_mem[a[7:2]] & ~strobe_mask(s)) | (d & strobe_mask(s));
            exp_mem_writes++;
            wr_addr_q.push_back(a[31:0]);
            wr_data_q.push_back(d);
            wr_strb_q.push_back(s);
         end
      end
   endtask

   task automatic send(input logic [32:0] a, input logic [31:0] d, input logic [3:0] s);
      int waited;
      avalid_i <= 1'b1;
      addr_i   <= a;
      wdata_i  <= d;
      wstrb_i  <= s;
      waited = 0;
      @(posedge clk);
      while (ready_o !== 1'b1) begin
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("host request was never accepted");
         end
         @(posedge clk);
      end
      model_access(a, d, s);
   endtask

   task automatic idle();
      avalid_i <= 1'b0;
      wstrb_i  <= 4'h0;
   endtask

   task automatic read_word(input int w);
      send({1'b0, w * 4}, 32'h0, 4'h0);
   endtask

   task automatic ctrl_access(input iob_cache_pkg::ctrl_reg_t sel, input logic write);
      send({1'b1, 30'd0, sel}, 32'h0, write ? 4'hF : 4'h0);
   endtask

   task automatic random_op(input int max_gap);
      logic [3:0] s;
      int         w;
      int         gap;
      w = $urandom_range(47, 0);
      s = $urandom_range(1, 0) ? 4'h0 : 4'($urandom_range(15, 1));
      send({1'b0, w * 4}, $urandom, s);
      gap = $urandom_range(max_gap, 0);
      if (gap > 0) begin
         idle();
         repeat (gap) @(posedge clk);
      end
   endtask

   // Sampled on the falling edge, where the port is settled
   task automatic drain();
      int waited;
      idle();
      waited = 0;
      @(negedge clk);
      while (!(ready_o && !mem_req_o && !mem_ack_i && exp_q.size() == 0
               && wr_addr_q.size() == 0)) begin
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("requests still outstanding, the cache stopped responding");
         end
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   task automatic finish_test(input string name);
      drain();
      check_value("memory read count", exp_mem_reads, mem_reads);
      check_value("memory write count", exp_mem_writes, mem_writes);
      test_count++;
      if (error_count != test_errors) begin
         failed_tests++;
      end
      $display("Test %0d %s: %s", test_count, name,
               (error_count == test_errors) ? "passed" : "failed");
      test_errors = error_count;
   endtask

   // External memory with a random acknowledge delay
   always @(posedge clk) begin
      if (mem_ack_i) begin
         mem_ack_i <= 1'b0;
      end else if (mem_req_o) begin
         if (!mem_busy) begin
            mem_busy = 1'b1;
            mem_wait = $urandom_range(max_delay, 0);
         end
         if (mem_wait == 0) begin
            mem_busy = 1'b0;
            check_value("memory address high bits", 32'h0, mem_addr_o & 32'hFFFF_FF00);
            if (!mem_we_o) begin
               mem_reads++;
               mem_rdata_i <= ext_mem[mem_addr_o[7:2]];
            end else if (wr_addr_q.size() == 0) begin
               $display("ERROR at %0t ns: unexpected write to memory at %h", $time, mem_addr_o);
               error_count++;
            end else begin
               mem_writes++;
               wr_mask = strobe_mask(wr_strb_q[0]);
               check_value("write address", wr_addr_q.pop_front(), mem_addr_o);
               check_value("write strobe", wr_strb_q.pop_front(), mem_wstrb_o);
               check_value("write data", wr_data_q.pop_front() & wr_mask, mem_wdata_o & wr_mask);
               ext_mem[mem_addr_o[7:2]] = (ext_mem[mem_addr_o[7:2]] & ~strobe_mask(mem_wstrb_o))
                                          | (mem_wdata_o & strobe_mask(mem_wstrb_o));
            end
            mem_ack_i <= 1'b1;
         end else begin
            mem_wait--;
         end
      end
   end

   // Read responses in request order
   always @(posedge clk) begin
      if (rvalid_o === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("ERROR at %0t ns: read data returned with no read outstanding", $time);
            error_count++;
         end else begin
            check_value($sformatf("read data at %h", exp_addr_q.pop_front()),
                        exp_q.pop_front(), rdata_o);
         end
      end
   end

   initial begin
      int waited;
      void'($urandom(75));
      avalid_i    = 1'b0;
      addr_i      = '0;
      wdata_i     = '0;
      wstrb_i     = '0;
      mem_rdata_i = '0;
      mem_ack_i   = 1'b0;
      for (int w = 0; w < WORDS; w++) begin
         ext_mem[w] = fill_word(w);
         ref_mem[w] = fill_word(w);
      end
      ref_valid = '0;
      max_delay = 5;
      waited = 0;
      while (rst_n !== 1'b1) begin
         waited++;
         if (waited > TIMEOUT) begin
            abort_run("reset was never released");
         end
         @(posedge clk);
      end
      @(negedge clk);
      check_value("ready after reset", 32'd1, ready_o);
      check_value("mem_req after reset", 32'd0, mem_req_o);
      check_value("rvalid after reset", 32'd0, rvalid_o);
      @(posedge clk);
      finish_test("reset state");

      repeat (200) random_op(3);
      finish_test("random reads and writes");

      ctrl_access(iob_cache_pkg::CTRL_HIT_CNT, 1'b0);
      ctrl_access(iob_cache_pkg::CTRL_MISS_CNT, 1'b0);
      ctrl_access(iob_cache_pkg::CTRL_RST_CNT, 1'b1);
      ctrl_access(iob_cache_pkg::CTRL_HIT_CNT, 1'b0);
      ctrl_access(iob_cache_pkg::CTRL_MISS_CNT, 1'b0);
      finish_test("hit and miss counters");

      for (int w = 0; w < 8; w++) begin
         read_word(w);
      end
      drain();
      reads_before = mem_reads;
      ctrl_access(iob_cache_pkg::CTRL_INVALIDATE, 1'b1);
      for (int w = 0; w < 8; w++) begin
         read_word(w);
      end
      ctrl_access(iob_cache_pkg::CTRL_MISS_CNT, 1'b0);
      drain();
      check_value("memory reads after invalidate", reads_before + 8, mem_reads);
      finish_test("invalidate");

      ctrl_access(iob_cache_pkg::CTRL_INVALIDATE, 1'b1);
      drain();
      reads_before = mem_reads;
      repeat (3) read_word(20);
      ctrl_access(iob_cache_pkg::CTRL_HIT_CNT, 1'b0);
      drain();
      check_value("memory reads for one miss and two hits", reads_before + 1, mem_reads);
      finish_test("hits stay off the memory port");

      max_delay = 12;
      repeat (300) random_op(0);
      ctrl_access(iob_cache_pkg::CTRL_HIT_CNT, 1'b0);
      ctrl_access(iob_cache_pkg::CTRL_MISS_CNT, 1'b0);
      finish_test("back-to-back with long memory delays");

      // Failed assertions of the bound checker
      error_count += dut0.props0.fail_count;
      $display("Tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
      if (error_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end
endmodule

`default_nettype wire

//--- iob_cache.f
iob_cache_pkg.sv
iob_cache_if.sv
iob_cache_front_end.sv
iob_cache_memory.sv
iob_cache_back_end.sv
iob_cache_control.sv
iob_cache.sv
iob_cache_clk_gen.sv
iob_cache_props.sv
iob_cache_tb.sv
